/* all.f */
src/mips_mem_pkg.sv
src/instr_decoder.sv
src/load_store.sv
src/mem_sequencer.sv
src/register_file.sv
src/ls_core.sv
tests/tb_mem_model.sv
tests/tb_ls_core.sv

/* Bender.yml */
package:
  name: ls_core

sources:
  - files:
      - src/mips_mem_pkg.sv
      - src/instr_decoder.sv
      - src/load_store.sv
      - src/mem_sequencer.sv
      - src/register_file.sv
      - src/ls_core.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_ls_core.sv

/* tests/tb_ls_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ls_core;
    import mips_mem_pkg::*;

    localparam int          timeout_cycles = 4000;
    localparam logic [31:0] data_base      = 32'h0000_0100;
    localparam logic [31:0] store_base     = 32'h0000_0200;

    logic        clk;
    logic        reset;
    logic        stall_en;
    logic [31:0] mem_address;
    logic [3:0]  mem_byteenable;
    logic [31:0] mem_writedata;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] mem_readdata;
    logic        waitrequest;

    string       test_name;
    int          pass_no;
    int          ref_idx;
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [3:0]  exp_be [$];
    logic [31:0] exp_data [$];
    logic [31:0] ref_addr [$];   // Write log of the run without stalls
    logic [3:0]  ref_be [$];
    logic [31:0] ref_data [$];

    ls_core DUT (
        .clk           (clk),
        .reset         (reset),
        .mem_address   (mem_address),
        .mem_byteenable(mem_byteenable),
        .mem_writedata (mem_writedata),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_readdata  (mem_readdata),
        .waitrequest   (waitrequest)
    );

    tb_mem_model u_mem (
        .clk        (clk),
        .reset      (reset),
        .stall_en   (stall_en),
        .address    (mem_address),
        .byteenable (mem_byteenable),
        .writedata  (mem_writedata),
        .read       (mem_read),
        .write      (mem_write),
        .readdata   (mem_readdata),
        .waitrequest(waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Byte i of a big-endian word sits at address+i, so on lane i
    function automatic logic [31:0] lane_word(input logic [31:0] w);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = w[31-8*i -: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // LWL: memory bytes k..3 fill the register from the top
    function automatic logic [31:0] merge_lwl(input logic [31:0] rt_val,
                                              input logic [31:0] mem_val, input int k);
        logic [31:0] res;
        res = rt_val;
        for (int i = 0; i + k < 4; i++) begin
            res[31-8*i -: 8] = mem_val[31-8*(i+k) -: 8];
        end
        return res;
    endfunction

    // LWR: memory bytes 0..k fill the register from the bottom
    function automatic logic [31:0] merge_lwr(input logic [31:0] rt_val,
                                              input logic [31:0] mem_val, input int k);
        logic [31:0] res;
        res = rt_val;
        for (int j = 0; j <= k; j++) begin
            res[31-8*(3-k+j) -: 8] = mem_val[31-8*j -: 8];
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] lanes);
        exp_addr.push_back(addr);
        exp_be.push_back(be);
        exp_data.push_back(lanes);
    endtask

    // SW of rt into the next free word of the store area
    task automatic store_word_expect(input logic [4:0] rt, input logic [31:0] value);
        logic [31:0] addr;
        addr = store_base + 32'(4 * exp_addr.size());
        prog.push_back(encode_itype(op_sw, 5'd0, rt, addr[15:0]));
        expect_write(addr, 4'hf, lane_word(value));
    endtask

    task automatic begin_test(input string name);
        @(negedge clk);
        reset = 1'b1;
        test_name = name;
        prog.delete();
        exp_addr.delete();
        exp_be.delete();
        exp_data.delete();
        u_mem.fill();
    endtask

    // Same writes with and without stalls, unused lanes included
    task automatic compare_runs(input int i);
        if (pass_no == 0) begin
            ref_addr.push_back(u_mem.log_addr[i]);
            ref_be.push_back(u_mem.log_be[i]);
            ref_data.push_back(u_mem.log_data[i]);
        end else begin
            check_value($sformatf("%s stalled write %0d address", test_name, i),
                        ref_addr[ref_idx], u_mem.log_addr[i]);
            check_value($sformatf("%s stalled write %0d byteenable", test_name, i),
                        {28'h0, ref_be[ref_idx]}, {28'h0, u_mem.log_be[i]});
            check_value($sformatf("%s stalled write %0d data", test_name, i),
                        ref_data[ref_idx], u_mem.log_data[i]);
            ref_idx++;
        end
    endtask

    task automatic run_program();
        int cycles;
        logic [31:0] m;
        for (int i = 0; i < 64; i++) begin
            if (i < prog.size()) begin
                u_mem.write_word(32'(4 * i), prog[i]);
            end else begin
                u_mem.write_word(32'(4 * i), 32'h0);  // Opcode 0 runs as a no-op
            end
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (u_mem.log_addr.size() < exp_addr.size() && cycles < timeout_cycles) begin
            @(negedge clk);
            check_value($sformatf("%s mem_read during mem_write", test_name),
                        32'h0, {31'h0, mem_read && mem_write});
            cycles++;
        end
        if (u_mem.log_addr.size() < exp_addr.size()) begin
            $display("Timeout: test %s finished only %0d of its %0d stores",
                     test_name, u_mem.log_addr.size(), exp_addr.size());
            $display("TB FAILED");
            $fatal(1);
        end
        for (int i = 0; i < exp_addr.size(); i++) begin
            m = lane_mask(exp_be[i]);
            check_value($sformatf("%s write %0d address", test_name, i),
                        exp_addr[i], u_mem.log_addr[i]);
            check_value($sformatf("%s write %0d byteenable", test_name, i),
                        {28'h0, exp_be[i]}, {28'h0, u_mem.log_be[i]});
            check_value($sformatf("%s write %0d data", test_name, i),
                        exp_data[i] & m, u_mem.log_data[i] & m);
            compare_runs(i);
        end
    endtask

    task automatic lw_sw_roundtrip();
        begin_test("lw_sw");
        u_mem.write_word(data_base, 32'h1234_5678);
        prog.push_back(encode_itype(op_lw, 5'd0, 5'd5, data_base[15:0]));
        store_word_expect(5'd5, 32'h1234_5678);
        run_program();
    endtask

    task automatic byte_half_stores();
        logic [31:0] src;
        logic [31:0] word_addr [6];
        logic [31:0] mem_exp [6];
        int          kk;
        src = 32'ha1b2_c3d4;
        begin_test("sb_sh");
        u_mem.write_word(data_base, src);
        prog.push_back(encode_itype(op_lw, 5'd0, 5'd1, data_base[15:0]));
        for (int k = 0; k < 4; k++) begin
            word_addr[k] = store_base + 32'(4 * k);
            mem_exp[k] = u_mem.read_word(word_addr[k]);
            mem_exp[k][31-8*k -: 8] = src[7:0];
            prog.push_back(encode_itype(op_sb, 5'd0, 5'd1, word_addr[k][15:0] + 16'(k)));
            expect_write(word_addr[k], 4'b0001 << k, 32'(src[7:0]) << (8 * k));
        end
        for (int h = 0; h < 2; h++) begin
            kk = 2 * h;
            word_addr[4+h] = store_base + 32'(16 + 4 * h);
            mem_exp[4+h] = u_mem.read_word(word_addr[4+h]);
            mem_exp[4+h][31-8*kk -: 16] = src[15:0];  // High byte at the lower address
            prog.push_back(encode_itype(op_sh, 5'd0, 5'd1, word_addr[4+h][15:0] + 16'(kk)));
            expect_write(word_addr[4+h], 4'b0011 << kk, 32'({src[7:0], src[15:8]}) << (8 * kk));
        end
        run_program();
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("%s memory word %0d", test_name, i),
                        mem_exp[i], u_mem.read_word(word_addr[i]));
        end
    endtask

    task automatic load_extension();
        logic [31:0] d;
        logic [7:0]  b;
        logic [15:0] h;
        d = 32'h8192_a3b4;  // Sign bit set in every byte
        begin_test("load_extend");
        u_mem.write_word(data_base, d);
        for (int k = 0; k < 4; k++) begin
            b = d[31-8*k -: 8];
            prog.push_back(encode_itype(op_lb, 5'd0, 5'd2, data_base[15:0] + 16'(k)));
            store_word_expect(5'd2, {{24{b[7]}}, b});
            prog.push_back(encode_itype(op_lbu, 5'd0, 5'd3, data_base[15:0] + 16'(k)));
            store_word_expect(5'd3, {24'h0, b});
        end
        for (int k = 0; k < 4; k += 2) begin
            h = d[31-8*k -: 16];
            prog.push_back(encode_itype(op_lh, 5'd0, 5'd2, data_base[15:0] + 16'(k)));
            store_word_expect(5'd2, {{16{h[15]}}, h});
            prog.push_back(encode_itype(op_lhu, 5'd0, 5'd3, data_base[15:0] + 16'(k)));
            store_word_expect(5'd3, {16'h0, h});
        end
        run_program();
    endtask

    task automatic lwl_lwr_merge();
        logic [31:0] d;
        logic [31:0] r3;
        d = 32'hc5d6_e7f8;
        begin_test("lwl_lwr");
        u_mem.write_word(data_base, d);
        for (int k = 0; k < 4; k++) begin
            prog.push_back(encode_itype(op_lui, 5'd0, 5'd3, 16'h1122));
            r3 = {16'h1122, 16'h0};
            prog.push_back(encode_itype(op_lwl, 5'd0, 5'd3, data_base[15:0] + 16'(k)));
            r3 = merge_lwl(r3, d, k);
            store_word_expect(5'd3, r3);
            prog.push_back(encode_itype(op_lwr, 5'd0, 5'd3, data_base[15:0] + 16'(k)));
            r3 = merge_lwr(r3, d, k);
            store_word_expect(5'd3, r3);
        end
        run_program();
    endtask

    task automatic r0_and_noop();
        logic [31:0] d;
        logic [31:0] addr;
        d = 32'h8765_4321;
        begin_test("r0_and_noop");
        u_mem.write_word(data_base, d);
        u_mem.write_word(data_base + 32'h4, ~d);
        prog.push_back(encode_itype(op_lw, 5'd0, 5'd1, data_base[15:0]));
        store_word_expect(5'd0, 32'h0);
        addr = store_base + 32'(4 * exp_addr.size());
        prog.push_back(encode_itype(op_sb, 5'd0, 5'd0, addr[15:0] + 16'd1));
        expect_write(addr, 4'b0010, 32'h0);
        prog.push_back(encode_itype(op_lb, 5'd0, 5'd0, data_base[15:0]));
        store_word_expect(5'd0, 32'h0);
        prog.push_back(encode_itype(op_lui, 5'd0, 5'd0, 16'hffff));
        store_word_expect(5'd0, 32'h0);
        // Unknown opcode aimed at r1 and at a word other than d
        prog.push_back(encode_itype(6'h3f, 5'd0, 5'd1, data_base[15:0] + 16'd4));
        store_word_expect(5'd1, d);
        run_program();
    endtask

    initial begin
        reset = 1'b1;
        stall_en = 1'b0;
        pass_no = 0;
        ref_idx = 0;
        u_mem.fill();
        for (int p = 0; p < 2; p++) begin
            @(negedge clk);
            pass_no = p;
            stall_en = (p == 1);  // Second pass with random waitrequest
            lw_sw_roundtrip();
            byte_half_stores();
            load_extension();
            lwl_lwr_merge();
            r0_and_noop();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_en,
    input  logic [31:0] address,
    input  logic [3:0]  byteenable,
    input  logic [31:0] writedata,
    input  logic        read,
    input  logic        write,
    output logic [31:0] readdata,
    output logic        waitrequest
);
    localparam int mem_bytes = 1024;

    logic [7:0] mem [mem_bytes];
    logic [1:0] wait_cnt;  // Stall cycles left before the pending request completes
    logic [9:0] base;
    int         seed = 32'hf739_64ae;
    int         rnd;

    // Completed writes, oldest first
    logic [31:0] log_addr [$];
    logic [3:0]  log_be [$];
    logic [31:0] log_data [$];

    assign base        = address[9:0];
    assign readdata    = {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    assign waitrequest = (read || write) && (wait_cnt != 2'd0);

    always @(posedge clk) begin
        if (reset) begin
            wait_cnt <= 2'd0;
            log_addr.delete();
            log_be.delete();
            log_data.delete();
        end else if (read || write) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                if (write) begin
                    for (int k = 0; k < 4; k++) begin
                        if (byteenable[k]) begin
                            mem[base + k] <= writedata[8*k +: 8];  // Lane k is byte base+k
                        end
                    end
                    log_addr.push_back(address);
                    log_be.push_back(byteenable);
                    log_data.push_back(writedata);
                end
                rnd = $random(seed);
                wait_cnt <= stall_en ? rnd[1:0] : 2'd0;  // Stall for the next request
            end
        end
    end

    task automatic fill();
        for (int i = 0; i < mem_bytes; i++) begin
            mem[i] = 8'(i * 37) ^ 8'(i >> 8) ^ 8'h3c;
        end
    endtask

    // Big-endian word access
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        for (int k = 0; k < 4; k++) begin
            mem[addr[9:0] + k] = data[31-8*k -: 8];
        end
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return {mem[addr[9:0]], mem[addr[9:0] + 1], mem[addr[9:0] + 2], mem[addr[9:0] + 3]};
    endfunction

endmodule

`default_nettype wire

/* src/ls_core.sv */
`timescale 1ns/10ps
`default_nettype none

module ls_core (
    input  logic                            clk,
    input  logic                            reset,
    output logic [mips_mem_pkg::xlen-1:0]   mem_address,
    output logic [mips_mem_pkg::xlen/8-1:0] mem_byteenable,
    output logic [mips_mem_pkg::xlen-1:0]   mem_writedata,
    output logic                            mem_read,
    output logic                            mem_write,
    input  logic [mips_mem_pkg::xlen-1:0]   mem_readdata,
    input  logic                            waitrequest
);
    import mips_mem_pkg::*;

    bus_req_t        bus_req;
    bus_req_t        data_req;
    decoded_t        dec;
    seq_state_e      state;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] load_word;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;
    logic [xlen-1:0] wb_data;
    logic            reg_we;

    mem_sequencer u_seq (
        .clk         (clk),
        .reset       (reset),
        .dec         (dec),
        .data_req    (data_req),
        .waitrequest (waitrequest),
        .mem_readdata(mem_readdata),
        .bus_req     (bus_req),
        .instr       (instr),
        .load_word   (load_word),
        .state       (state),
        .reg_we      (reg_we)
    );

    instr_decoder u_dec (
        .instr(instr),
        .dec  (dec)
    );

    load_store u_ls (
        .state    (state),
        .dec      (dec),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .load_word(load_word),
        .data_req (data_req),
        .wb_data  (wb_data)
    );

    // Writeback always targets rt
    register_file u_rf (
        .clk    (clk),
        .reset  (reset),
        .rs_addr(dec.rs),
        .rt_addr(dec.rt),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .we     (reg_we),
        .waddr  (dec.rt),
        .wdata  (wb_data)
    );

    assign mem_address    = bus_req.address;
    assign mem_byteenable = bus_req.byteenable;
    assign mem_writedata  = bus_req.writedata;
    assign mem_read       = bus_req.read;
    assign mem_write      = bus_req.write;

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mips_mem_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_mem_pkg::reg_addr_w-1:0] rt_addr,
    output logic [mips_mem_pkg::xlen-1:0]       rs_data,
    output logic [mips_mem_pkg::xlen-1:0]       rt_data,
    input  logic                                we,
    input  logic [mips_mem_pkg::reg_addr_w-1:0] waddr,
    input  logic [mips_mem_pkg::xlen-1:0]       wdata
);
    import mips_mem_pkg::*;

    localparam int reg_count = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads, r0 hardwired to zero
    always_comb begin
        if (rs_addr == '0) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_addr];
        end
    end

    always_comb begin
        if (rt_addr == '0) begin
            rt_data = '0;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

endmodule

`default_nettype wire

/* src/mem_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  mips_mem_pkg::decoded_t        dec,
    input  mips_mem_pkg::bus_req_t        data_req,
    input  logic                          waitrequest,
    input  logic [mips_mem_pkg::xlen-1:0] mem_readdata,
    output mips_mem_pkg::bus_req_t        bus_req,
    output logic [mips_mem_pkg::xlen-1:0] instr,
    output logic [mips_mem_pkg::xlen-1:0] load_word,
    output mips_mem_pkg::seq_state_e      state,
    output logic                          reg_we
);
    import mips_mem_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] rdata_int;   // Read data in internal order
    logic            needs_bus;
    logic            writes_reg;
    logic            xfer_done;

    assign rdata_int  = swap_bytes(mem_readdata);
    assign needs_bus  = !(dec.op inside {none, lui});
    assign writes_reg = dec.op inside {lb, lbu, lh, lhu, lw, lwl, lwr, lui};

    // Fetch request or the load/store data phase
    always_comb begin
        case (state)
            fetch: begin
                bus_req = '{
                    address:    pc,
                    byteenable: all_lanes,
                    writedata:  '0,
                    read:       1'b1,
                    write:      1'b0
                };
            end
            exec1: begin
                bus_req = needs_bus ? data_req : '0;
            end
            default: begin
                bus_req = '0;
            end
        endcase
    end

    assign xfer_done = (bus_req.read || bus_req.write) && !waitrequest;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch;
            pc    <= reset_pc;
        end else begin
            case (state)
                fetch: begin
                    if (xfer_done) begin
                        state <= exec1;
                    end
                end
                exec1: begin
                    if (!needs_bus || xfer_done) begin
                        state <= exec2;
                    end
                end
                default: begin
                    state <= fetch;
                    pc    <= pc + xlen'(4);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fetch && xfer_done) begin
            instr <= rdata_int;
        end
        if (state == exec1 && xfer_done && bus_req.read) begin
            load_word <= rdata_int;
        end
    end

    assign reg_we = (state == exec2) && writes_reg && (dec.rt != '0);  // r0 never written

    // Stalled request held until the slave accepts it
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (bus_req.read || bus_req.write) && waitrequest |=> $stable(bus_req))
        else $error("bus request changed while waitrequest was high");

endmodule

`default_nettype wire

/* src/load_store.sv */
`timescale 1ns/10ps
`default_nettype none

module load_store (
    input  mips_mem_pkg::seq_state_e      state,
    input  mips_mem_pkg::decoded_t        dec,
    input  logic [mips_mem_pkg::xlen-1:0] rs_data,
    input  logic [mips_mem_pkg::xlen-1:0] rt_data,
    input  logic [mips_mem_pkg::xlen-1:0] load_word,  // Internal order
    output mips_mem_pkg::bus_req_t        data_req,
    output logic [mips_mem_pkg::xlen-1:0] wb_data
);
    import mips_mem_pkg::*;

    logic [xlen-1:0]   imm_sext;
    logic [xlen-1:0]   eff_addr;
    logic [1:0]        k;         // Byte offset, byte 0 is the MSB
    logic [4:0]        shl_amt;   // 8*k
    logic [4:0]        shr_amt;   // 8*(3-k)
    logic [xlen/8-1:0] be_int;    // Bit 3 is byte 0
    logic [xlen-1:0]   wdata_int;
    logic [xlen-1:0]   ld_shl;
    logic [xlen-1:0]   keep_lwl;
    logic [xlen-1:0]   keep_lwr;
    logic              is_load;
    logic              is_store;
    logic              is_half;

    assign imm_sext = {{16{dec.imm[15]}}, dec.imm};
    assign eff_addr = rs_data + imm_sext;
    assign k        = eff_addr[1:0];
    assign shl_amt  = {k, 3'b000};
    assign shr_amt  = {~k, 3'b000};

    assign is_load  = dec.op inside {lb, lbu, lh, lhu, lw, lwl, lwr};
    assign is_store = dec.op inside {sb, sh, sw};
    assign is_half  = dec.op inside {lh, lhu, sh};

    // Enables in internal order, swapped to bus lanes below
    always_comb begin
        case (dec.op)
            lb, lbu, sb: begin
                be_int = 4'b1000 >> k;
            end
            lh, lhu, sh: begin
                be_int = 4'b1100 >> k;
            end
            lwl: begin
                be_int = all_lanes >> k;     // Bytes k to 3
            end
            lwr: begin
                be_int = ~(4'b0111 >> k);    // Bytes 0 to k
            end
            lw, sw: begin
                be_int = all_lanes;
            end
            default: begin
                be_int = 4'b0000;
            end
        endcase
    end

    // Store data lined up under the selected bytes
    always_comb begin
        case (dec.op)
            sb: begin
                wdata_int = {rt_data[7:0], 24'h00_0000} >> shl_amt;
            end
            sh: begin
                wdata_int = {rt_data[15:0], 16'h0000} >> shl_amt;
            end
            sw: begin
                wdata_int = rt_data;
            end
            default: begin
                wdata_int = '0;
            end
        endcase
    end

    assign data_req = '{
        address:    {eff_addr[xlen-1:2], 2'b00},
        byteenable: swap_lanes(be_int),
        writedata:  swap_bytes(wdata_int),
        read:       is_load,
        write:      is_store
    };

    // Selected byte or half moved to the top of the word
    assign ld_shl = load_word << shl_amt;

    // Register bits that LWL and LWR leave alone
    assign keep_lwl = rt_data & ~({xlen{1'b1}} << shl_amt);
    assign keep_lwr = rt_data & ~({xlen{1'b1}} >> shr_amt);

    always_comb begin
        case (dec.op)
            lb: begin
                wb_data = {{24{ld_shl[31]}}, ld_shl[31:24]};
            end
            lbu: begin
                wb_data = {24'h00_0000, ld_shl[31:24]};
            end
            lh: begin
                wb_data = {{16{ld_shl[31]}}, ld_shl[31:16]};
            end
            lhu: begin
                wb_data = {16'h0000, ld_shl[31:16]};
            end
            lw: begin
                wb_data = load_word;
            end
            lui: begin
                wb_data = {dec.imm, 16'h0000};
            end
            lwl: begin
                wb_data = ld_shl | keep_lwl;
            end
            lwr: begin
                wb_data = (load_word >> shr_amt) | keep_lwr;
            end
            default: begin
                wb_data = '0;
            end
        endcase
    end

    // Offset comes from register contents, so it is only known here
    always_comb begin
        if (state == exec1) begin
            if (is_half) begin
                assert #0 (k[0] == 1'b0)
                    else $error("halfword access at odd byte offset %0d", k);
            end
        end
    end

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  logic [mips_mem_pkg::xlen-1:0] instr,
    output mips_mem_pkg::decoded_t        dec
);
    import mips_mem_pkg::*;

    logic [5:0] opcode;
    mem_op_e    op_sel;

    assign opcode = instr[31:26];

    // Only the memory opcodes and LUI are recognised
    always_comb begin
        case (opcode)
            op_lb: begin
                op_sel = lb;
            end
            op_lbu: begin
                op_sel = lbu;
            end
            op_lh: begin
                op_sel = lh;
            end
            op_lhu: begin
                op_sel = lhu;
            end
            op_lw: begin
                op_sel = lw;
            end
            op_lwl: begin
                op_sel = lwl;
            end
            op_lwr: begin
                op_sel = lwr;
            end
            op_sb: begin
                op_sel = sb;
            end
            op_sh: begin
                op_sel = sh;
            end
            op_sw: begin
                op_sel = sw;
            end
            op_lui: begin
                op_sel = lui;
            end
            default: begin
                op_sel = none;  // Runs as a no-op
            end
        endcase
    end

    // I-type field layout
    assign dec = '{
        op:  op_sel,
        rs:  instr[25:21],
        rt:  instr[20:16],
        imm: instr[15:0]
    };

endmodule

`default_nettype wire

/* src/mips_mem_pkg.sv */
`default_nettype none

package mips_mem_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam logic [xlen-1:0]   reset_pc  = 32'h0000_0000;
    localparam logic [xlen/8-1:0] all_lanes = 4'b1111;

    // Primary opcode field, instruction bits 31:26
    localparam logic [5:0] op_lb  = 6'h20;
    localparam logic [5:0] op_lh  = 6'h21;
    localparam logic [5:0] op_lwl = 6'h22;
    localparam logic [5:0] op_lw  = 6'h23;
    localparam logic [5:0] op_lbu = 6'h24;
    localparam logic [5:0] op_lhu = 6'h25;
    localparam logic [5:0] op_lwr = 6'h26;
    localparam logic [5:0] op_sb  = 6'h28;
    localparam logic [5:0] op_sh  = 6'h29;
    localparam logic [5:0] op_sw  = 6'h2b;
    localparam logic [5:0] op_lui = 6'h0f;

    typedef enum logic [3:0] {
        none, lb, lbu, lh, lhu, lw, lwl, lwr, sb, sh, sw, lui
    } mem_op_e;

    typedef struct packed {
        mem_op_e               op;
        logic [reg_addr_w-1:0] rs;  // Base register
        logic [reg_addr_w-1:0] rt;  // Source or destination
        logic [15:0]           imm;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0]   address;     // Word aligned
        logic [xlen/8-1:0] byteenable;  // Bit k is byte address+k
        logic [xlen-1:0]   writedata;   // Byte address+k on bits 8k+7:8k
        logic              read;
        logic              write;
    } bus_req_t;

    typedef enum logic [1:0] {
        fetch, exec1, exec2
    } seq_state_e;

    // Bus lane order to internal big-endian order and back
    function automatic logic [xlen-1:0] swap_bytes(input logic [xlen-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Same reordering for byte enables
    function automatic logic [xlen/8-1:0] swap_lanes(input logic [xlen/8-1:0] be);
        return {be[0], be[1], be[2], be[3]};
    endfunction

endpackage

`default_nettype wire
